// File: flist.f
+incdir+design
design/wb_split_pkg.sv
design/wb_request_switch.sv
design/wb_target_port.sv
design/wb_response_merge.sv
design/wb_split_top.sv
testbench/wb_split_properties.sv
testbench/tb_wb_split.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build tb_wb_split with Verilator, run it, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_wb_split -f flist.f
	-./obj_dir/Vtb_wb_split > sim.log 2>&1
	@cat sim.log
	@if grep -q "FAIL: see errors above" sim.log || ! grep -q "PASS: all tests" sim.log; then \
	  echo "simulation failed"; \
	  exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: testbench/wb_split_patterns.txt
// op (1 write, 0 read) _ address _ write data _ sel _ expected read data _ expected err
// read data is only compared when no error is expected
1_0003_11110003_f_00000000_0
1_4003_22224003_f_00000000_0
0_0003_00000000_f_11110003_0
0_4003_00000000_f_22224003_0
1_0003_0000abcd_3_00000000_0
0_0003_00000000_f_1111abcd_0
1_8007_bcbc0007_f_00000000_0
0_0007_00000000_f_bcbc0007_0
0_4007_00000000_f_bcbc0007_0
0_8007_00000000_f_00000000_1
1_c001_12345678_f_00000000_1
0_c001_00000000_f_00000000_1
1_0004_00000004_f_00000000_0
1_2004_deadbeef_f_00000000_1
0_0004_00000000_f_00000004_0
0_6004_00000000_f_00000000_1
1_4009_00001009_f_00000000_0
1_9009_cafe0009_f_00000000_1
0_1009_00000000_f_cafe0009_0
0_5009_00000000_f_00000000_1
0_4009_00000000_f_00001009_0

// File: testbench/tb_wb_split.sv
`timescale 1ns/1ns
`include "wb_split_cfg.svh"

module tb_wb_split;
  import wb_split_pkg::*;

  localparam int MAX_PAT = 64;

  logic        i_clk = 1'b0;
  logic        i_rst_n;
  logic        i_cyc;
  logic        i_stb;
  logic        i_we;
  addr_t       i_adr;
  data_t       i_dat;
  sel_t        i_sel;
  logic        o_ack;
  logic        o_err;
  data_t       o_dat;
  logic [1:0]  tcyc;
  logic [1:0]  tstb;
  logic [1:0]  tack;
  logic [1:0]  terr;
  logic [1:0]  active;            // target has seen the strobe and is stalling
  logic [1:0]  left [2];          // stall cycles still to go
  wb_req_t     treq [2];
  data_t       trdat [2];
  data_t       mem [2][64];
  int          strobes [2] = '{0, 0};
  int          pulses = 0;
  int          n_pat = 0;
  logic [31:0] rng = 32'hf19;
  logic [91:0] pats [MAX_PAT];    // op, adr, wdata, sel, rdata, err

  always #20 i_clk = ~i_clk;

  wb_split_top i_wb_split_top (
    .i_clk, .i_rst_n, .i_cyc, .i_stb, .i_we, .i_adr, .i_dat, .i_sel, .o_ack, .o_err, .o_dat,
    .o_t0_cyc (tcyc[0]), .o_t0_stb (tstb[0]), .o_t0_req (treq[0]), .i_t0_ack (tack[0]),
    .i_t0_err (terr[0]), .i_t0_dat (trdat[0]), .o_t1_cyc (tcyc[1]), .o_t1_stb (tstb[1]),
    .o_t1_req (treq[1]), .i_t1_ack (tack[1]), .i_t1_err (terr[1]), .i_t1_dat (trdat[1])
  );

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(data_t got, data_t exp, string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_err(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, expected %b, got %b", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    if (got != exp) begin
      $display("FAILED at %0t ns: %s, expected %0d, got %0d", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_quiet(string when);
    check_err(o_ack, 1'b0, {"o_ack ", when});
    check_err(o_err, 1'b0, {"o_err ", when});
    check_err(tcyc[0], 1'b0, {"target 0 cycle ", when});
    check_err(tcyc[1], 1'b0, {"target 1 cycle ", when});
    check_err(tstb[0], 1'b0, {"target 0 strobe ", when});
    check_err(tstb[1], 1'b0, {"target 1 strobe ", when});
  endtask

  // target 0 errs on offset bit 13, target 1 also on bit 12 so a broadcast can split
  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      tack   <= 2'b00;
      terr   <= 2'b00;
      active <= 2'b00;
    end else begin
      for (int t = 0; t < 2; t++) begin
        tack[t] <= 1'b0;
        terr[t] <= 1'b0;
        if (tcyc[t] && tstb[t] && !tack[t] && !terr[t]) begin
          if (!active[t]) begin
            rng = xorshift(rng);
            active[t]  <= 1'b1;
            left[t]    <= rng[1:0];  // 0 to 3 extra stall cycles
            strobes[t] <= strobes[t] + 1;
          end else if (left[t] != 2'd0) begin
            left[t] <= left[t] - 2'd1;
          end else if (treq[t].adr[13] || (t == 1 && treq[t].adr[12])) begin
            active[t] <= 1'b0;
            terr[t]   <= 1'b1;  // no write on error
          end else begin
            active[t] <= 1'b0;
            tack[t]   <= 1'b1;
            trdat[t]  <= treq[t].we ? '0 : mem[t][treq[t].adr[5:0]];
            for (int b = 0; b < 4; b++) begin
              if (treq[t].we && treq[t].sel[b]) begin
                mem[t][treq[t].adr[5:0]][8*b +: 8] <= treq[t].dat[8*b +: 8];
              end
            end
          end
        end
      end
    end
  end

  always @(posedge i_clk) begin
    if (o_ack || o_err) begin
      pulses <= pulses + 1;
    end
  end

  task automatic run_access(logic [91:0] p, int idx);
    logic       is_we;
    addr_t      a;
    logic [1:0] win;
    int         want0;
    int         want1;
    int         seen0;
    int         seen1;
    int         seen_pulses;
    data_t      got_dat;
    logic       got_err;
    string      tag;
    is_we = p[88];
    a = p[87:72];
    win = a[`WB_ADDR_W-1:`WB_OFFSET_W];
    tag = $sformatf("pattern %0d (adr %h)", idx, a);
    want0 = (win == `WIN_T0 || (win == `WIN_BCAST && is_we)) ? 1 : 0;
    want1 = (win == `WIN_T1 || (win == `WIN_BCAST && is_we)) ? 1 : 0;
    seen0 = strobes[0];
    seen1 = strobes[1];
    seen_pulses = pulses;
    @(posedge i_clk);
    i_cyc <= 1'b1;
    i_stb <= 1'b1;
    i_we  <= is_we;
    i_adr <= a;
    i_dat <= p[71:40];
    i_sel <= p[39:36];
    do begin
      @(posedge i_clk);
    end while (!o_ack && !o_err);
    got_dat = o_dat;
    got_err = o_err;
    i_cyc <= 1'b0;
    i_stb <= 1'b0;
    @(posedge i_clk);
    @(negedge i_clk);  // a second pulse would be counted by now
    check_err(got_err, p[0], {tag, " status"});
    if (!p[0] && (!is_we || win == `WIN_BCAST)) begin
      check_data(got_dat, p[35:4], {tag, " data"});
    end
    check_count(strobes[0] - seen0, want0, {tag, " target 0 strobes"});
    check_count(strobes[1] - seen1, want1, {tag, " target 1 strobes"});
    check_count(pulses - seen_pulses, 1, {tag, " host pulses"});
  endtask

  initial begin
    int count;
    count   = 0;
    i_rst_n = 1'b0;
    i_cyc   = 1'b0;
    i_stb   = 1'b0;
    i_we    = 1'b0;
    i_adr   = '0;
    i_dat   = '0;
    i_sel   = '0;
    for (int i = 0; i < MAX_PAT; i++) begin
      pats[i] = '1;  // op nibble f marks the end
    end
    $readmemh("testbench/wb_split_patterns.txt", pats);
    while (count < MAX_PAT && pats[count][91:88] != 4'hf) begin
      count++;
    end
    if (count == 0) begin
      $display("ERROR: no access patterns were read from the pattern file");
      stop_run();
    end
    n_pat = count;
    repeat (5) begin
      @(negedge i_clk);
      check_quiet("during reset");
    end
    @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    check_quiet("after reset");
    for (int k = 0; k < n_pat; k++) begin
      run_access(pats[k], k);
    end
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    wait (n_pat > 0);
    #((n_pat + 1) * 16 * 40);
    $display("ERROR: watchdog expired, the DUT stopped answering the host");
    stop_run();
  end

endmodule

// File: testbench/wb_split_properties.sv
`timescale 1ns/1ns
`include "wb_split_cfg.svh"

module wb_split_properties (
  input logic                i_clk,
  input logic                i_rst_n,
  input logic                i_cyc,
  input logic                i_stb,
  input logic                i_we,
  input wb_split_pkg::addr_t i_adr,
  input logic                o_ack,
  input logic                o_err,
  input logic                o_t0_stb,
  input logic                i_t0_ack,
  input logic                i_t0_err,
  input logic                o_t1_stb,
  input logic                i_t1_ack,
  input logic                i_t1_err
);

  logic [1:0] win;
  logic       stb_q;
  logic       new_reject;  // fresh host request that the splitter answers itself

  always_comb begin
    win        = i_adr[`WB_ADDR_W-1:`WB_OFFSET_W];
    new_reject = i_cyc && i_stb && !stb_q &&
                 ((win == `WIN_NONE) || ((win == `WIN_BCAST) && !i_we));
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      stb_q <= 1'b0;
    end else begin
      stb_q <= i_stb;
    end
  end

  ack_err_apart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_ack && o_err)) else $error("o_ack and o_err high in the same cycle");

  ack_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ack |=> !o_ack) else $error("o_ack high for two cycles");

  t0_stb_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_t0_stb && !i_t0_ack && !i_t0_err) |=> o_t0_stb) else $error("target 0 strobe dropped");

  t1_stb_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_t1_stb && !i_t1_ack && !i_t1_err) |=> o_t1_stb) else $error("target 1 strobe dropped");

  reject_time: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $past(new_reject, 2) |-> (o_err && !$past(o_err))) else $error("reject error not 2 cycles");

endmodule

bind wb_split_top wb_split_properties u_props (.*);

// File: design/wb_split_top.sv
`timescale 1ns/1ns

module wb_split_top (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_cyc,
  input  var logic                  i_stb,
  input  var logic                  i_we,
  input  var wb_split_pkg::addr_t   i_adr,
  input  var wb_split_pkg::data_t   i_dat,
  input  var wb_split_pkg::sel_t    i_sel,
  output var logic                  o_ack,
  output var logic                  o_err,
  output var wb_split_pkg::data_t   o_dat,
  output var logic                  o_t0_cyc,
  output var logic                  o_t0_stb,
  output var wb_split_pkg::wb_req_t o_t0_req,
  input  var logic                  i_t0_ack,
  input  var logic                  i_t0_err,
  input  var wb_split_pkg::data_t   i_t0_dat,
  output var logic                  o_t1_cyc,
  output var logic                  o_t1_stb,
  output var wb_split_pkg::wb_req_t o_t1_req,
  input  var logic                  i_t1_ack,
  input  var logic                  i_t1_err,
  input  var wb_split_pkg::data_t   i_t1_dat
);
  import wb_split_pkg::*;

  logic       start;
  logic [1:0] launch;
  route_e     route;
  wb_req_t    req;
  logic       done0;
  logic       done1;
  wb_rsp_t    rsp0;
  wb_rsp_t    rsp1;
  logic       complete;

  wb_request_switch u_switch (
    .i_clk, .i_rst_n, .i_cyc, .i_stb, .i_we, .i_adr, .i_dat, .i_sel,
    .i_complete (complete), .o_start (start), .o_launch (launch),
    .o_route (route), .o_req (req)
  );

  wb_target_port u_port0 (
    .i_clk, .i_rst_n, .i_launch (launch[0]), .i_req (req),
    .o_done (done0), .o_rsp (rsp0), .o_cyc (o_t0_cyc), .o_stb (o_t0_stb),
    .o_req (o_t0_req), .i_ack (i_t0_ack), .i_err (i_t0_err), .i_dat (i_t0_dat)
  );

  wb_target_port u_port1 (
    .i_clk, .i_rst_n, .i_launch (launch[1]), .i_req (req),
    .o_done (done1), .o_rsp (rsp1), .o_cyc (o_t1_cyc), .o_stb (o_t1_stb),
    .o_req (o_t1_req), .i_ack (i_t1_ack), .i_err (i_t1_err), .i_dat (i_t1_dat)
  );

  wb_response_merge u_merge (
    .i_clk, .i_rst_n, .i_start (start), .i_route (route),
    .i_done0 (done0), .i_done1 (done1), .i_rsp0 (rsp0), .i_rsp1 (rsp1),
    .o_ack, .o_err, .o_dat, .o_complete (complete)
  );

endmodule

// File: design/wb_response_merge.sv
`timescale 1ns/1ns

module wb_response_merge (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_start,
  input  var wb_split_pkg::route_e  i_route,
  input  var logic                  i_done0,
  input  var logic                  i_done1,
  input  var wb_split_pkg::wb_rsp_t i_rsp0,
  input  var wb_split_pkg::wb_rsp_t i_rsp1,
  output var logic                  o_ack,
  output var logic                  o_err,
  output var wb_split_pkg::data_t   o_dat,
  output var logic                  o_complete
);
  import wb_split_pkg::*;

  logic [1:0] pending;
  logic [1:0] pending_left;
  logic       fire;
  logic       rsp_err;
  data_t      rsp_dat;

  always_comb begin
    pending_left = pending & ~{i_done1, i_done0};
    fire         = (i_start && (i_route == ROUTE_REJECT)) ||
                   ((pending != 2'b00) && (pending_left == 2'b00));
    case (i_route)
      ROUTE_T0: begin
        rsp_err = i_rsp0.err;
        rsp_dat = i_rsp0.dat;
      end
      ROUTE_T1: begin
        rsp_err = i_rsp1.err;
        rsp_dat = i_rsp1.dat;
      end
      ROUTE_BOTH: begin
        rsp_err = i_rsp0.err | i_rsp1.err;
        rsp_dat = '0;
      end
      default: begin  // reject, answered here
        rsp_err = 1'b1;
        rsp_dat = '0;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      pending    <= 2'b00;
      o_ack      <= 1'b0;
      o_err      <= 1'b0;
      o_complete <= 1'b0;
    end else begin
      pending    <= i_start ? route_mask(i_route) : pending_left;
      o_ack      <= fire && !rsp_err;
      o_err      <= fire && rsp_err;
      o_complete <= fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (fire) begin
      o_dat <= rsp_dat;
    end
  end

endmodule

// File: design/wb_target_port.sv
`timescale 1ns/1ns

module wb_target_port (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_launch,
  input  var wb_split_pkg::wb_req_t i_req,
  output var logic                  o_done,
  output var wb_split_pkg::wb_rsp_t o_rsp,
  output var logic                  o_cyc,
  output var logic                  o_stb,
  output var wb_split_pkg::wb_req_t o_req,
  input  var logic                  i_ack,
  input  var logic                  i_err,
  input  var wb_split_pkg::data_t   i_dat
);
  import wb_split_pkg::*;

  port_state_e state;
  logic        answered;

  always_comb begin
    answered = (state == PT_CYCLE) && (i_ack || i_err);
    o_cyc    = (state == PT_CYCLE);
    o_stb    = (state == PT_CYCLE);  // held until the target answers
    o_done   = (state == PT_DONE);
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= PT_IDLE;
    end else begin
      case (state)
        PT_IDLE: begin
          if (i_launch) begin
            state <= PT_CYCLE;
          end
        end
        PT_CYCLE: begin
          if (answered) begin
            state <= PT_DONE;
          end
        end
        PT_DONE: state <= PT_IDLE;
        default: state <= PT_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((state == PT_IDLE) && i_launch) begin
      o_req <= i_req;
    end
  end

  // result stays put until the next launch
  always_ff @(posedge i_clk) begin
    if (answered) begin
      o_rsp.dat <= i_dat;
      o_rsp.err <= i_err;  // err wins if both are seen
    end
  end

endmodule

// File: design/wb_request_switch.sv
`timescale 1ns/1ns
`include "wb_split_cfg.svh"

module wb_request_switch (
  input  var logic                  i_clk,
  input  var logic                  i_rst_n,
  input  var logic                  i_cyc,
  input  var logic                  i_stb,
  input  var logic                  i_we,
  input  var wb_split_pkg::addr_t   i_adr,
  input  var wb_split_pkg::data_t   i_dat,
  input  var wb_split_pkg::sel_t    i_sel,
  input  var logic                  i_complete,
  output var logic                  o_start,
  output var logic [1:0]            o_launch,
  output var wb_split_pkg::route_e  o_route,
  output var wb_split_pkg::wb_req_t o_req
);
  import wb_split_pkg::*;

  switch_state_e                          state;
  logic [`WB_ADDR_W-`WB_OFFSET_W-1:0]     win;
  logic                                   take;
  route_e                                 route_d;
  wb_req_t                                req_d;

  function automatic route_e decode_route(
    logic [`WB_ADDR_W-`WB_OFFSET_W-1:0] window,
    logic                               we
  );
    case (window)
      `WIN_T0:    return ROUTE_T0;
      `WIN_T1:    return ROUTE_T1;
      `WIN_BCAST: return we ? ROUTE_BOTH : ROUTE_REJECT;  // no broadcast reads
      default:    return ROUTE_REJECT;
    endcase
  endfunction

  always_comb begin
    win       = i_adr[`WB_ADDR_W-1:`WB_OFFSET_W];
    take      = (state == SW_IDLE) && i_cyc && i_stb;
    route_d   = decode_route(win, i_we);
    req_d.we  = i_we;
    req_d.adr = i_adr[`WB_OFFSET_W-1:0];  // strip window bits
    req_d.dat = i_dat;
    req_d.sel = i_sel;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= SW_IDLE;
      o_start  <= 1'b0;
      o_launch <= 2'b00;
      o_route  <= ROUTE_REJECT;
    end else begin
      o_start  <= take;
      o_launch <= take ? route_mask(route_d) : 2'b00;  // single-cycle pulse
      case (state)
        SW_IDLE: begin
          if (take) begin
            state   <= SW_BUSY;
            o_route <= route_d;
          end
        end
        SW_BUSY: begin
          if (i_complete) begin
            state <= SW_IDLE;
          end
        end
        default: state <= SW_IDLE;
      endcase
    end
  end

  // request held stable for the whole busy period
  always_ff @(posedge i_clk) begin
    if (take) begin
      o_req <= req_d;
    end
  end

endmodule

// File: design/wb_split_pkg.sv
`include "wb_split_cfg.svh"

package wb_split_pkg;

  typedef logic [`WB_ADDR_W-1:0]   addr_t;
  typedef logic [`WB_OFFSET_W-1:0] offset_t;  // window bits removed
  typedef logic [`WB_DATA_W-1:0]   data_t;
  typedef logic [`WB_SEL_W-1:0]    sel_t;

  typedef struct packed {
    logic    we;
    offset_t adr;
    data_t   dat;
    sel_t    sel;
  } wb_req_t;

  typedef struct packed {
    data_t dat;
    logic  err;
  } wb_rsp_t;

  typedef enum logic [1:0] {ROUTE_T0, ROUTE_T1, ROUTE_BOTH, ROUTE_REJECT} route_e;

  typedef enum logic {SW_IDLE, SW_BUSY} switch_state_e;

  typedef enum logic [1:0] {PT_IDLE, PT_CYCLE, PT_DONE} port_state_e;

  // bit 0 is port 0, bit 1 is port 1
  function automatic logic [1:0] route_mask(route_e route);
    case (route)
      ROUTE_T0:   return 2'b01;
      ROUTE_T1:   return 2'b10;
      ROUTE_BOTH: return 2'b11;
      default:    return 2'b00;
    endcase
  endfunction

endpackage

// File: design/wb_split_cfg.svh
`ifndef WB_SPLIT_CFG_SVH
`define WB_SPLIT_CFG_SVH

// host address and the part of it a target sees
`define WB_ADDR_W    16
`define WB_OFFSET_W  14

// data path
`define WB_DATA_W    32
`define WB_SEL_W     4

// window codes, taken from the top address bits
`define WIN_T0       2'd0
`define WIN_T1       2'd1
`define WIN_BCAST    2'd2  // writes go to both targets
`define WIN_NONE     2'd3  // unmapped

`endif
